/* vita_pkg.sv */
/*
 * Shared types for the VITA-49 receive framing path: flag bits, packet
 * lines, framing configuration, settings offsets and framer states
 */
package vita_pkg;

   localparam int TIME_W = 64;

   // Flags carried with every sample word, error flags in bits 4 to 1
   typedef struct packed {
      logic zerolen;
      logic overrun;
      logic brokenchain;
      logic latecmd;
      logic eob;
   } flags_t;

   // One entry of the output FIFO
   typedef struct packed {
      logic        sof;
      logic        eof;
      logic [31:0] data;
   } pkt_line_t;

   typedef struct packed {
      logic [31:0] header;
      logic [31:0] streamid;
      logic [31:0] trailer;
      logic [15:0] samples_per_pkt;
      logic [3:0]  numchan;
   } frame_cfg_t;

   // Register offsets on the settings bus, added to the block base address
   typedef enum logic [7:0] {
      SET_HEADER   = 8'd4,
      SET_STREAMID = 8'd5,
      SET_TRAILER  = 8'd6,
      SET_SAMPS    = 8'd7,
      SET_NUMCHAN  = 8'd8
   } set_addr_e;

   typedef enum logic [3:0] {
      ST_IDLE         = 4'd0,
      ST_HEADER       = 4'd1,
      ST_STREAMID     = 4'd2,
      ST_SECS         = 4'd3,
      ST_TICS         = 4'd4,
      ST_TICS2        = 4'd5,
      ST_PAYLOAD      = 4'd6,
      ST_TRAILER      = 4'd7,
      ST_ERR_HEADER   = 4'd9,
      ST_ERR_STREAMID = 4'd10,
      ST_ERR_SECS     = 4'd11,
      ST_ERR_TICS     = 4'd12,
      ST_ERR_TICS2    = 4'd13,
      ST_ERR_PAYLOAD  = 4'd14
   } frame_state_e;

endpackage

/* vita_settings.sv */
/*
 * Settings bus decode into the framing configuration registers,
 * with a pulse on stream ID writes
 */
`timescale 1ns/1ps

module vita_settings #(
   parameter int SET_BASE = 0
) (
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  logic                 set_stb_i,
   input  logic [7:0]           set_addr_i,
   input  logic [31:0]          set_data_i,
   output vita_pkg::frame_cfg_t cfg_o,
   output logic                 streamid_wr_o
);

   logic [7:0] set_offset;

   // Offset relative to the block base, wraps like an 8-bit address compare
   assign set_offset = set_addr_i - 8'(SET_BASE);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cfg_o.header          <= '0;
         cfg_o.streamid        <= '0;
         cfg_o.trailer         <= '0;
         cfg_o.samples_per_pkt <= '0;
         cfg_o.numchan         <= 4'd1;
         streamid_wr_o         <= 1'b0;
      end
      else
      begin
         streamid_wr_o <= set_stb_i && (set_offset == vita_pkg::SET_STREAMID);
         if (set_stb_i)
         begin
            case (set_offset)
               vita_pkg::SET_HEADER:   cfg_o.header          <= set_data_i;
               vita_pkg::SET_STREAMID: cfg_o.streamid        <= set_data_i;
               vita_pkg::SET_TRAILER:  cfg_o.trailer         <= set_data_i;
               vita_pkg::SET_SAMPS:    cfg_o.samples_per_pkt <= set_data_i[15:0];
               vita_pkg::SET_NUMCHAN:  cfg_o.numchan         <= set_data_i[3:0];
               default:
               begin
               end
            endcase
         end
      end
   end

endmodule

/* vita_rx_framer.sv */
/*
 * Framing state machine: wraps timestamped sample words into IF data
 * packets, or extension context packets when error flags are set
 */
`timescale 1ns/1ps

module vita_rx_framer #(
   parameter int MAX_CHAN = 4
) (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  vita_pkg::frame_cfg_t          cfg_i,
   input  logic                          streamid_wr_i,
   input  vita_pkg::flags_t              sample_flags_i,
   input  logic [vita_pkg::TIME_W-1:0]   sample_time_i,
   input  logic [32*MAX_CHAN-1:0]        sample_data_i,
   input  logic                          sample_valid_i,
   output logic                          sample_ready_o,
   output vita_pkg::pkt_line_t           line_o,
   output logic                          line_valid_o,
   input  logic                          line_ready_i
);

   vita_pkg::frame_state_e state;
   logic [3:0]  phase;
   logic [15:0] sample_ctr;
   logic [3:0]  pkt_count;
   logic        trl_eob;
   logic [31:0] chan_word;
   logic [15:0] pkt_len;
   logic        err_flags;
   logic        any_flag;
   logic        last_chan;

   assign err_flags = sample_flags_i.zerolen | sample_flags_i.overrun |
                      sample_flags_i.brokenchain | sample_flags_i.latecmd;
   assign any_flag  = err_flags | sample_flags_i.eob;
   assign last_chan = (phase == cfg_i.numchan - 4'd1);
   assign pkt_len   = cfg_i.samples_per_pkt + 16'd6;

   // Channel slot picked by the phase counter
   always_comb
   begin
      chan_word = 32'h0;
      for (int i = 0; i < MAX_CHAN; i++)
      begin
         if (phase == 4'(i))
            chan_word = sample_data_i[32*i +: 32];
      end
   end

   always_comb
   begin
      line_o.sof  = 1'b0;
      line_o.eof  = 1'b0;
      line_o.data = 32'h0;
      case (state)
         vita_pkg::ST_HEADER:
         begin
            line_o.sof  = 1'b1;
            line_o.data = {3'b000, cfg_i.header[28], 2'b01, cfg_i.header[25:20],
                           pkt_count, pkt_len};
         end
         vita_pkg::ST_STREAMID, vita_pkg::ST_ERR_STREAMID:
            line_o.data = cfg_i.streamid;
         vita_pkg::ST_SECS, vita_pkg::ST_ERR_SECS:
            line_o.data = sample_time_i[vita_pkg::TIME_W-1 -: 32];
         vita_pkg::ST_TICS2, vita_pkg::ST_ERR_TICS2:
            line_o.data = sample_time_i[31:0];
         vita_pkg::ST_PAYLOAD:
            line_o.data = chan_word;
         vita_pkg::ST_TRAILER:
         begin
            line_o.eof  = 1'b1;
            line_o.data = {cfg_i.trailer[31:21], 1'b1, cfg_i.trailer[19:9], trl_eob, 8'h00};
         end
         // Extension context packet, no trailer
         vita_pkg::ST_ERR_HEADER:
         begin
            line_o.sof  = 1'b1;
            line_o.data = {8'h50, cfg_i.header[23:20], pkt_count, 16'd6};
         end
         vita_pkg::ST_ERR_PAYLOAD:
         begin
            line_o.eof  = 1'b1;
            line_o.data = {27'd0, sample_flags_i};
         end
         default:
         begin
         end
      endcase
   end

   // Error samples never go into a data payload
   assign line_valid_o = (state != vita_pkg::ST_IDLE) &&
                         ((state != vita_pkg::ST_PAYLOAD) || (sample_valid_i && !err_flags));

   assign sample_ready_o = line_ready_i &&
                           (((state == vita_pkg::ST_PAYLOAD) && last_chan && !err_flags) ||
                            (state == vita_pkg::ST_ERR_PAYLOAD));

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         pkt_count <= 4'd0;
      else if (streamid_wr_i)
         pkt_count <= 4'd0;
      else if ((state == vita_pkg::ST_TRAILER) && line_ready_i)
         pkt_count <= pkt_count + 4'd1;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state      <= vita_pkg::ST_IDLE;
         phase      <= 4'd0;
         sample_ctr <= 16'd0;
         trl_eob    <= 1'b0;
      end
      else if (state == vita_pkg::ST_IDLE)
      begin
         phase      <= 4'd0;
         sample_ctr <= 16'd1;
         trl_eob    <= 1'b0;
         if (sample_valid_i)
            state <= err_flags ? vita_pkg::ST_ERR_HEADER : vita_pkg::ST_HEADER;
      end
      else if ((state == vita_pkg::ST_PAYLOAD) && sample_valid_i && err_flags)
         // Close the data packet, the error sample is picked up again from idle
         state <= vita_pkg::ST_TRAILER;
      else if (line_ready_i)
      begin
         case (state)
            vita_pkg::ST_HEADER:
               state <= cfg_i.header[28] ? vita_pkg::ST_STREAMID : vita_pkg::ST_SECS;
            vita_pkg::ST_STREAMID:     state <= vita_pkg::ST_SECS;
            vita_pkg::ST_SECS:         state <= vita_pkg::ST_TICS;
            vita_pkg::ST_TICS:         state <= vita_pkg::ST_TICS2;
            vita_pkg::ST_TICS2:        state <= vita_pkg::ST_PAYLOAD;
            vita_pkg::ST_PAYLOAD:
            begin
               if (sample_valid_i)
               begin
                  if (last_chan)
                  begin
                     phase      <= 4'd0;
                     sample_ctr <= sample_ctr + 16'd1;
                     trl_eob    <= sample_flags_i.eob;
                     if ((sample_ctr == cfg_i.samples_per_pkt) || any_flag)
                        state <= vita_pkg::ST_TRAILER;
                  end
                  else
                     phase <= phase + 4'd1;
               end
            end
            vita_pkg::ST_ERR_HEADER:   state <= vita_pkg::ST_ERR_STREAMID;
            vita_pkg::ST_ERR_STREAMID: state <= vita_pkg::ST_ERR_SECS;
            vita_pkg::ST_ERR_SECS:     state <= vita_pkg::ST_ERR_TICS;
            vita_pkg::ST_ERR_TICS:     state <= vita_pkg::ST_ERR_TICS2;
            vita_pkg::ST_ERR_TICS2:    state <= vita_pkg::ST_ERR_PAYLOAD;
            default:                   state <= vita_pkg::ST_IDLE;
         endcase
      end
   end

endmodule

/* pkt_fifo.sv */
/*
 * Short synchronous FIFO of packet lines, ready/valid on both sides
 */
`timescale 1ns/1ps

module pkt_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input  logic                clk,
   input  logic                arst_n_i,
   input  vita_pkg::pkt_line_t wr_line_i,
   input  logic                wr_valid_i,
   output logic                wr_ready_o,
   output vita_pkg::pkt_line_t rd_line_o,
   output logic                rd_valid_o,
   input  logic                rd_ready_i
);

   localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

   vita_pkg::pkt_line_t mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [FIFO_DEPTH_LOG2:0]   count;
   logic                       do_wr;
   logic                       do_rd;

   assign rd_valid_o = (count != '0);
   // A full buffer still takes a line when the head leaves on the same edge
   assign wr_ready_o = (count != (FIFO_DEPTH_LOG2+1)'(DEPTH)) || rd_ready_i;
   assign do_wr      = wr_valid_i && wr_ready_o;
   assign do_rd      = rd_valid_o && rd_ready_i;
   assign rd_line_o  = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_line_i;
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

endmodule

/* vita_rx_top.sv */
/*
 * Receive framing top level: settings decode, framer and output FIFO
 */
`timescale 1ns/1ps

module vita_rx_top #(
   parameter int SET_BASE        = 0,
   parameter int MAX_CHAN        = 4,
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input  logic                        clk,
   input  logic                        arst_n_i,
   input  logic                        set_stb_i,
   input  logic [7:0]                  set_addr_i,
   input  logic [31:0]                 set_data_i,
   input  vita_pkg::flags_t            sample_flags_i,
   input  logic [vita_pkg::TIME_W-1:0] sample_time_i,
   input  logic [32*MAX_CHAN-1:0]      sample_data_i,
   input  logic                        sample_valid_i,
   output logic                        sample_ready_o,
   output vita_pkg::pkt_line_t         line_o,
   output logic                        line_valid_o,
   input  logic                        line_ready_i
);

   vita_pkg::frame_cfg_t cfg;
   vita_pkg::pkt_line_t  wr_line;
   logic                 streamid_wr;
   logic                 wr_valid;
   logic                 wr_ready;

   vita_settings #(.SET_BASE(SET_BASE)) u_settings (
      .clk(clk), .arst_n_i(arst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .cfg_o(cfg), .streamid_wr_o(streamid_wr)
   );

   vita_rx_framer #(.MAX_CHAN(MAX_CHAN)) u_framer (
      .clk(clk), .arst_n_i(arst_n_i), .cfg_i(cfg), .streamid_wr_i(streamid_wr),
      .sample_flags_i(sample_flags_i), .sample_time_i(sample_time_i),
      .sample_data_i(sample_data_i), .sample_valid_i(sample_valid_i),
      .sample_ready_o(sample_ready_o),
      .line_o(wr_line), .line_valid_o(wr_valid), .line_ready_i(wr_ready)
   );

   pkt_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fifo (
      .clk(clk), .arst_n_i(arst_n_i),
      .wr_line_i(wr_line), .wr_valid_i(wr_valid), .wr_ready_o(wr_ready),
      .rd_line_o(line_o), .rd_valid_o(line_valid_o), .rd_ready_i(line_ready_i)
   );

endmodule

/* tb_vita_rx.sv */
/*
 * Testbench for the receive framing top level: test table, reference
 * packet builder, line collector with LFSR back-pressure and a watchdog
 */
`timescale 1ns/1ps

module tb_vita_rx;

   localparam int NTESTS   = 10;
   localparam int MAX_CHAN = 4;
   localparam int SET_BASE = 32;

   typedef struct packed {
      logic [31:0] header;
      logic [31:0] streamid;
      logic [31:0] trailer;
      logic [15:0] spp;
      logic [3:0]  numchan;
      logic [7:0]  nsamp;
      logic [4:0]  flag_val;
      logic [7:0]  flag_idx;
      logic        bp;
   } test_row_t;

   logic                        clk;
   logic                        arst_n_i;
   logic                        set_stb_i;
   logic [7:0]                  set_addr_i;
   logic [31:0]                 set_data_i;
   vita_pkg::flags_t            sample_flags_i;
   logic [vita_pkg::TIME_W-1:0] sample_time_i;
   logic [32*MAX_CHAN-1:0]      sample_data_i;
   logic                        sample_valid_i;
   logic                        sample_ready_o;
   vita_pkg::pkt_line_t         line_o;
   logic                        line_valid_o;
   logic                        line_ready_i;

   test_row_t           tests [NTESTS];
   vita_pkg::pkt_line_t exp_q [$];
   int                  exp_end [NTESTS];
   int                  rx_idx;
   int                  errors;
   int                  cycles;
   int                  limit;
   logic                bp_on;
   logic [31:0]         lfsr;

   // A short FIFO so that back-pressure really fills it and stalls the framer
   vita_rx_top #(.SET_BASE(SET_BASE), .MAX_CHAN(MAX_CHAN), .FIFO_DEPTH_LOG2(2)) uut (
      .clk(clk), .arst_n_i(arst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .sample_flags_i(sample_flags_i), .sample_time_i(sample_time_i),
      .sample_data_i(sample_data_i), .sample_valid_i(sample_valid_i),
      .sample_ready_o(sample_ready_o),
      .line_o(line_o), .line_valid_o(line_valid_o), .line_ready_i(line_ready_i)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      else
         return s >> 1;
   endfunction

   function automatic logic take_bit();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr_step(lfsr);
      return b;
   endfunction

   function automatic logic [4:0] flags_of(input int t, input int g);
      return (g == int'(tests[t].flag_idx)) ? tests[t].flag_val : 5'd0;
   endfunction

   function automatic logic [31:0] sample_word(input int t, input int g, input int c);
      return {8'(t), 8'h5a, 8'(g), 8'(c)};
   endfunction

   function automatic logic [63:0] test_time(input int t);
      return {32'h0000_1000 + 32'(t), 32'h8000_0000 + 32'(t * 17)};
   endfunction

   function automatic void add_line(input logic sof, input logic eof, input logic [31:0] data);
      exp_q.push_back({sof, eof, data});
   endfunction

   // Seconds, zero fractional word, then low time word
   function automatic void add_time_lines(input logic [63:0] tm);
      add_line(1'b0, 1'b0, tm[63:32]);
      add_line(1'b0, 1'b0, 32'h0);
      add_line(1'b0, 1'b0, tm[31:0]);
   endfunction

   function automatic void fill_table();
      // header, stream ID, trailer, spp, channels, samples, flag, flag index, back-pressure
      tests[0] = '{32'h1000_0000, 32'h0000_1234, 32'ha5a5_5a5a, 16'd4, 4'd1, 8'd4, 5'd0, 8'd0, 1'b0};
      tests[1] = '{32'h0030_0000, 32'h0000_0000, 32'h0000_0000, 16'd3, 4'd4, 8'd6, 5'd0, 8'd0, 1'b0};
      tests[2] = '{32'hefff_ffff, 32'h0000_0077, 32'hffff_ffff, 16'd2, 4'd2, 8'd4, 5'd0, 8'd0, 1'b0};
      tests[3] = '{32'h0000_0000, 32'h0000_0042, 32'h0000_0000, 16'd4, 4'd2, 8'd6, 5'd1, 8'd1, 1'b0};
      tests[4] = '{32'h1050_0000, 32'hcafe_0001, 32'h0000_0000, 16'd3, 4'd1, 8'd6, 5'd8, 8'd2, 1'b0};
      tests[5] = '{32'h0000_0000, 32'h0000_0005, 32'h0000_0000, 16'd1, 4'd1, 8'd18, 5'd0, 8'd0, 1'b0};
      // Rows 0 to 3 again under back-pressure
      for (int i = 0; i < 4; i++)
      begin
         tests[6+i]    = tests[i];
         tests[6+i].bp = 1'b1;
      end
   endfunction

   // Packet count restarts in every test since each test rewrites the stream ID
   function automatic void build_expected(input int t);
      test_row_t   r;
      logic [63:0] tm;
      logic [4:0]  f;
      logic [3:0]  cnt;
      logic        eob;
      logic        done;
      int          g;
      int          n;
      r   = tests[t];
      tm  = test_time(t);
      cnt = 4'd0;
      g   = 0;
      while (g < int'(r.nsamp))
      begin
         f = flags_of(t, g);
         if (f[4:1] != 4'd0)
         begin
            add_line(1'b1, 1'b0, {8'h50, r.header[23:20], cnt, 16'd6});
            add_line(1'b0, 1'b0, r.streamid);
            add_time_lines(tm);
            add_line(1'b0, 1'b1, {27'd0, f});
            g++;
         end
         else
         begin
            add_line(1'b1, 1'b0, {3'b000, r.header[28], 2'b01, r.header[25:20], cnt,
                                  r.spp + 16'd6});
            if (r.header[28])
               add_line(1'b0, 1'b0, r.streamid);
            add_time_lines(tm);
            n    = 0;
            eob  = 1'b0;
            done = 1'b0;
            while (!done && (g < int'(r.nsamp)))
            begin
               f = flags_of(t, g);
               if (f[4:1] != 4'd0)
                  done = 1'b1;
               else
               begin
                  for (int c = 0; c < int'(r.numchan); c++)
                     add_line(1'b0, 1'b0, sample_word(t, g, c));
                  n++;
                  g++;
                  eob  = f[0];
                  done = (n == int'(r.spp)) || f[0];
               end
            end
            add_line(1'b0, 1'b1, {r.trailer[31:21], 1'b1, r.trailer[19:9], eob, 8'h00});
            cnt = cnt + 4'd1;
         end
      end
      exp_end[t] = exp_q.size();
   endfunction

   task automatic write_setting(input vita_pkg::set_addr_e offs, input logic [31:0] val);
      @(posedge clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= 8'(SET_BASE) + offs;
      set_data_i <= val;
   endtask

   task automatic feed_samples(input int t);
      logic [32*MAX_CHAN-1:0] d;
      for (int g = 0; g < int'(tests[t].nsamp); g++)
      begin
         for (int c = 0; c < MAX_CHAN; c++)
            d[32*c +: 32] = sample_word(t, g, c);
         sample_valid_i <= 1'b1;
         sample_flags_i <= flags_of(t, g);
         sample_time_i  <= test_time(t);
         sample_data_i  <= d;
         do
            @(posedge clk);
         while (!sample_ready_o);
      end
      sample_valid_i <= 1'b0;
   endtask

   // Collector compares each accepted line, then draws the next ready
   always @(posedge clk)
   begin
      if (line_valid_o && line_ready_i)
      begin
         if (rx_idx >= exp_q.size())
         begin
            $display("Unexpected extra line %h at time %0t", line_o, $time);
            errors++;
         end
         else if (line_o !== exp_q[rx_idx])
         begin
            $display("ERR %0t: line %0d expected %h got %h", $time, rx_idx, exp_q[rx_idx], line_o);
            errors++;
         end
         rx_idx++;
      end
      line_ready_i <= bp_on ? take_bit() : 1'b1;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > limit)
      begin
         $display("Timeout after %0d cycles, %0d of %0d lines received", cycles, rx_idx,
                  exp_q.size());
         $display("Simulation failed");
         $finish;
      end
   end

   initial
   begin
      int first_err;
      int first_line;
      clk            = 1'b0;
      arst_n_i       = 1'b0;
      set_stb_i      = 1'b0;
      set_addr_i     = 8'h0;
      set_data_i     = 32'h0;
      sample_flags_i = '0;
      sample_time_i  = '0;
      sample_data_i  = '0;
      sample_valid_i = 1'b0;
      line_ready_i   = 1'b0;
      bp_on          = 1'b0;
      lfsr           = 32'h8b07ebd2;
      rx_idx         = 0;
      errors         = 0;
      cycles         = 0;
      fill_table();
      for (int t = 0; t < NTESTS; t++)
         build_expected(t);
      limit = exp_q.size() * 8 + 200;
      repeat (4) @(posedge clk);
      // Framer idle and FIFO empty while reset holds
      if ((sample_ready_o !== 1'b0) || (line_valid_o !== 1'b0))
      begin
         $display("ERR %0t: reset state sample_ready %b line_valid %b, expected 0 0",
                  $time, sample_ready_o, line_valid_o);
         errors++;
      end
      arst_n_i <= 1'b1;
      for (int t = 0; t < NTESTS; t++)
      begin
         first_err  = errors;
         first_line = rx_idx;
         bp_on <= tests[t].bp;
         write_setting(vita_pkg::SET_HEADER, tests[t].header);
         write_setting(vita_pkg::SET_STREAMID, tests[t].streamid);
         write_setting(vita_pkg::SET_TRAILER, tests[t].trailer);
         write_setting(vita_pkg::SET_SAMPS, {16'h0, tests[t].spp});
         write_setting(vita_pkg::SET_NUMCHAN, {28'h0, tests[t].numchan});
         @(posedge clk);
         set_stb_i <= 1'b0;
         repeat (2) @(posedge clk);
         feed_samples(t);
         wait (rx_idx >= exp_end[t]);
         if (errors == first_err)
            $display("test %0d ok, %0d lines", t, rx_idx - first_line);
         else
            $display("test %0d FAIL, %0d errors", t, errors - first_err);
      end
      repeat (10) @(posedge clk);
      $display("%0d tests, %0d lines checked, %0d errors", NTESTS, rx_idx, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* sources.f */
vita_pkg.sv
vita_settings.sv
vita_rx_framer.sv
pkt_fifo.sv
vita_rx_top.sv
tb_vita_rx.sv

/* Makefile */
SIM = obj_dir/Vtb_vita_rx

.PHONY: all run clean

all: run

$(SIM): sources.f $(shell cat sources.f)
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_vita_rx -o Vtb_vita_rx

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
